//--- filelist.f
verilog/conv_pkg.sv
verilog/map_pkg.sv
verilog/psum_if.sv
verilog/sram.sv
verilog/address_counter.sv
verilog/one_hot_counter.sv
verilog/psum_fifo.sv
verilog/pe.sv
verilog/load_sequencer.sv
verilog/datapath_top.sv
bench/datapath_tb.sv

//--- Bender.yml
package:
  name: row_conv_datapath

sources:
  - files:
      - verilog/conv_pkg.sv
      - verilog/map_pkg.sv
      - verilog/psum_if.sv
      - verilog/sram.sv
      - verilog/address_counter.sv
      - verilog/one_hot_counter.sv
      - verilog/psum_fifo.sv
      - verilog/pe.sv
      - verilog/load_sequencer.sv
      - verilog/datapath_top.sv

  - target: test
    files:
      - bench/datapath_tb.sv

//--- bench/datapath_tb.sv
`timescale 1ns/1ns

module datapath_tb import conv_pkg::*; import map_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int RUNS           = 20;

    logic              clk;
    logic              reset;
    logic              start;
    logic [1:0]        taps;
    logic              stride2;
    logic              ext_wen;
    logic [ADDR_W-1:0] ext_addr;
    sram_word_u        ext_wdata;
    logic [ADDR_W-1:0] ext_raddr;
    sram_word_u        ext_rdata;
    logic              busy;
    logic              done_all;

    int errors;
    int checks;
    bit timed_out;

    // reference copies of what sits in the sram
    operand_t filt_m [NUM_PE][MAX_TAPS];
    operand_t ifm_m [NUM_PE][ROW_LEN];
    psum_t    model_mem [2**ADDR_W];

    datapath_top dut_i (
        .clk(clk),
        .reset(reset),
        .start(start),
        .taps(taps),
        .stride2(stride2),
        .ext_wen(ext_wen),
        .ext_addr(ext_addr),
        .ext_wdata(ext_wdata),
        .ext_raddr(ext_raddr),
        .ext_rdata(ext_rdata),
        .busy(busy),
        .done_all(done_all)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input psum_t exp, input psum_t got);
        checks++;
        assert (got === exp) else begin
            $display("FAILED t=%0t %s: expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic write_word(input int addr, input sram_word_u data);
        @(posedge clk);
        ext_wen   <= 1'b1;
        ext_addr  <= ADDR_W'(addr);
        ext_wdata <= data;
        @(posedge clk);         // sram takes the word here
        ext_wen <= 1'b0;
        model_mem[addr] = data.psum;
    endtask

    task automatic read_word(input int addr, output sram_word_u data);
        @(posedge clk);
        ext_raddr <= ADDR_W'(addr);
        @(posedge clk);
        @(negedge clk);         // one cycle read latency
        data = ext_rdata;
    endtask

    function automatic operand_t rand_operand(input bit near_max);
        if (near_max) begin
            return 8'd255 - 8'($urandom % 4);
        end else begin
            return 8'($urandom);
        end
    endfunction

    // filters, ifmaps and a random result region mirrored in the model
    task automatic load_operands(input bit near_max);
        sram_word_u w;
        for (int k = 0; k < NUM_PE; k++) begin
            for (int t = 0; t < MAX_TAPS; t++) filt_m[k][t] = rand_operand(near_max);
            for (int p = 0; p < ROW_LEN; p++) ifm_m[k][p] = rand_operand(near_max);
            w.ops[0] = filt_m[k][0];
            w.ops[1] = filt_m[k][1];
            write_word(FILT_BASE + FILT_WORDS*k, w);
            w.ops[0] = filt_m[k][2];
            w.ops[1] = rand_operand(near_max);     // pad byte the PE skips
            write_word(FILT_BASE + FILT_WORDS*k + 1, w);
            for (int i = 0; i < IF_WORDS; i++) begin
                w.ops[0] = ifm_m[k][2*i];
                w.ops[1] = ifm_m[k][2*i+1];
                write_word(IF_BASE + IF_WORDS*k + i, w);
            end
        end
        for (int a = RES_BASE; a < RES_BASE + ROW_LEN; a++) begin
            w.psum = psum_t'($urandom);
            write_word(a, w);
        end
    endtask

    // out[j] = sum over PE k and tap t of if[k][j*s+t] * f[k][t] mod 2^16
    task automatic compute_model(input int taps_n, input int stride);
        int n_out;
        int acc;
        n_out = (ROW_LEN - taps_n) / stride + 1;
        for (int j = 0; j < n_out; j++) begin
            acc = 0;
            for (int k = 0; k < NUM_PE; k++) begin
                for (int t = 0; t < taps_n; t++) begin
                    acc = (acc + int'(ifm_m[k][j*stride+t]) * int'(filt_m[k][t])) & 32'hffff;
                end
            end
            model_mem[RES_BASE + j] = psum_t'(acc);
        end
    endtask

    task automatic check_results();
        sram_word_u got;
        for (int a = RES_BASE; a < RES_BASE + ROW_LEN; a++) begin
            read_word(a, got);
            check_value($sformatf("ext_rdata[%0d]", a), model_mem[a], got.psum);
        end
    endtask

    task automatic pulse_start(input int taps_n, input int stride);
        @(posedge clk);
        start   <= 1'b1;
        taps    <= 2'(taps_n);
        stride2 <= (stride == 2);
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (done_all !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            check_value("busy", 1, busy);   // held for the whole run
            cycles++;
            @(negedge clk);
        end
        if (done_all !== 1'b1) begin
            $display("timeout: done_all still low %0d cycles after start", TIMEOUT_CYCLES);
            errors++;
            timed_out = 1'b1;
        end else begin
            check_value("busy", 0, busy);
        end
    endtask

    task automatic run_conv(input int taps_n, input int stride);
        pulse_start(taps_n, stride);
        @(negedge clk);
        check_value("done_all", 0, done_all);
        check_value("busy", 1, busy);
        wait_done();
        if (!timed_out) begin
            compute_model(taps_n, stride);
            check_results();
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - err_before);
        end
    endtask

    initial begin : main_seq
        int         err_before;
        int         taps_n;
        int         stride;
        sram_word_u w;
        sram_word_u got;

        clk       = 1'b0;
        reset     = 1'b1;
        start     = 1'b0;
        taps      = 2'd3;
        stride2   = 1'b0;
        ext_wen   = 1'b0;
        ext_addr  = '0;
        ext_wdata = '0;
        ext_raddr = '0;
        errors    = 0;
        checks    = 0;
        timed_out = 1'b0;
        void'($urandom(32'ha111));

        repeat (2) @(posedge clk);
        reset <= 1'b0;

        err_before = errors;
        @(negedge clk);
        check_value("busy", 0, busy);
        check_value("done_all", 0, done_all);
        w.psum = psum_t'($urandom);
        write_word(RES_BASE + ROW_LEN, w);
        read_word(RES_BASE + ROW_LEN, got);
        check_value("ext_rdata", w.psum, got.psum);
        report_test(1, "reset state and external access", err_before);

        err_before = errors;
        load_operands(1'b0);
        run_conv(3, 1);
        report_test(2, "taps 3 stride 1", err_before);

        if (!timed_out) begin
            err_before = errors;
            for (int r = 0; r < RUNS && !timed_out; r++) begin
                taps_n = 1 + ($urandom % 3);
                stride = 1 + ($urandom % 2);
                load_operands(1'b0);
                run_conv(taps_n, stride);
            end
            report_test(3, "random taps and stride", err_before);
        end

        // back to back starts from the done state
        if (!timed_out) begin
            err_before = errors;
            @(negedge clk);
            check_value("done_all", 1, done_all);
            load_operands(1'b0);
            run_conv(2, 2);
            if (!timed_out) begin
                run_conv(1, 1);
            end
            report_test(4, "busy and done_all handshake", err_before);
        end

        if (!timed_out) begin
            err_before = errors;
            load_operands(1'b1);
            run_conv(3, 1);
            if (!timed_out) begin
                load_operands(1'b1);
                run_conv(3, 2);
            end
            report_test(5, "wrapping sums", err_before);
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- verilog/datapath_top.sv
`timescale 1ns/1ns

module datapath_top import conv_pkg::*; import map_pkg::*; #(
    parameter int ADDR_WIDTH      = ADDR_W,
    parameter int PSUM_FIFO_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic [1:0]            taps,
    input  logic                  stride2,
    input  logic                  ext_wen,
    input  logic [ADDR_WIDTH-1:0] ext_addr,
    input  sram_word_u            ext_wdata,
    input  logic [ADDR_WIDTH-1:0] ext_raddr,
    output sram_word_u            ext_rdata,
    output logic                  busy,
    output logic                  done_all
);

    logic [ADDR_WIDTH-1:0] seq_raddr;
    logic [ADDR_WIDTH-1:0] seq_waddr;
    logic [ADDR_WIDTH-1:0] raddr;
    logic [ADDR_WIDTH-1:0] waddr;
    sram_word_u            seq_wdata;
    sram_word_u            wdata;
    sram_word_u            rdata;
    logic                  seq_wen;
    logic                  wen;

    logic [NUM_PE-1:0] pe_wen;
    logic              pe_is_filt;
    logic              pe_start;
    logic              res_ren;
    logic              res_empty;
    logic              res_last;
    psum_t             res_data;

    // external access only between runs
    assign raddr     = busy ? seq_raddr : ext_raddr;
    assign waddr     = busy ? seq_waddr : ext_addr;
    assign wdata     = busy ? seq_wdata : ext_wdata;
    assign wen       = busy ? seq_wen : ext_wen;
    assign ext_rdata = rdata;

    sram #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) sram_i (
        .clk(clk),
        .raddr(raddr),
        .waddr(waddr),
        .wen(wen),
        .wdata(wdata),
        .rdata(rdata)
    );

    load_sequencer #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) seq_i (
        .clk(clk),
        .reset(reset),
        .start(start),
        .res_empty(res_empty),
        .res_data(res_data),
        .res_last(res_last),
        .raddr(seq_raddr),
        .pe_wen(pe_wen),
        .pe_is_filt(pe_is_filt),
        .pe_start(pe_start),
        .res_ren(res_ren),
        .waddr(seq_waddr),
        .wdata(seq_wdata),
        .wen(seq_wen),
        .busy(busy),
        .done_all(done_all)
    );

    // link[0] is the idle input of PE0 and link[NUM_PE] feeds the result FIFO
    psum_if link [NUM_PE+1] ();

    assign link[0].wen  = 1'b0;
    assign link[0].data = '0;
    assign link[0].last = 1'b0;

    for (genvar i = 0; i < NUM_PE; i++) begin : g_pe
        pe #(
            .FIRST(i == 0),
            .PSUM_FIFO_DEPTH(PSUM_FIFO_DEPTH)
        ) pe_i (
            .clk(clk),
            .reset(reset),
            .wen(pe_wen[i]),
            .is_filt(pe_is_filt),
            .din(rdata),        // shared read bus
            .start(pe_start),
            .taps(taps),
            .stride2(stride2),
            .up(link[i]),
            .down(link[i+1])
        );
    end

    // PE2 output buffer drained by write-back
    psum_fifo #(
        .PSUM_FIFO_DEPTH(PSUM_FIFO_DEPTH)
    ) res_fifo (
        .clk(clk),
        .reset(reset),
        .wen(link[NUM_PE].wen),
        .din(link[NUM_PE].data),
        .din_last(link[NUM_PE].last),
        .ren(res_ren),
        .dout(res_data),
        .dout_last(res_last),
        .full(link[NUM_PE].full),
        .empty(res_empty)
    );

endmodule

//--- verilog/load_sequencer.sv
`timescale 1ns/1ns

module load_sequencer import conv_pkg::*; import map_pkg::*; #(
    parameter int ADDR_WIDTH = ADDR_W
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  res_empty,
    input  psum_t                 res_data,
    input  logic                  res_last,
    output logic [ADDR_WIDTH-1:0] raddr,
    output logic [NUM_PE-1:0]     pe_wen,
    output logic                  pe_is_filt,
    output logic                  pe_start,
    output logic                  res_ren,
    output logic [ADDR_WIDTH-1:0] waddr,
    output sram_word_u            wdata,
    output logic                  wen,
    output logic                  busy,
    output logic                  done_all
);

    localparam logic [2:0] S_IDLE      = 3'd0;
    localparam logic [2:0] S_LOAD_FILT = 3'd1;
    localparam logic [2:0] S_LOAD_IF   = 3'd2;
    localparam logic [2:0] S_SETTLE    = 3'd3;
    localparam logic [2:0] S_LAUNCH    = 3'd4;
    localparam logic [2:0] S_COMPUTE   = 3'd5;
    localparam logic [2:0] S_DONE      = 3'd6;

    logic [2:0]            state;
    logic                  run_clear;
    logic                  rd_en;
    logic                  filt_co;
    logic                  if_co;
    logic [ADDR_WIDTH-1:0] filt_addr;
    logic [ADDR_WIDTH-1:0] if_addr;
    logic [NUM_PE-1:0]     pe_sel;

    assign run_clear = start && (state == S_IDLE || state == S_DONE);
    assign rd_en = (state == S_LOAD_FILT) || (state == S_LOAD_IF);
    assign raddr = (state == S_LOAD_IF) ? if_addr : filt_addr;

    address_counter #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .OFFSET(FILT_BASE),
        .WRAP_LEN(FILT_WORDS)
    ) filt_cnt (
        .clk(clk),
        .reset(reset),
        .clear(run_clear),
        .enable(state == S_LOAD_FILT),
        .addr(filt_addr),
        .co(filt_co)
    );

    address_counter #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .OFFSET(IF_BASE),
        .WRAP_LEN(IF_WORDS)
    ) if_cnt (
        .clk(clk),
        .reset(reset),
        .clear(run_clear),
        .enable(state == S_LOAD_IF),
        .addr(if_addr),
        .co(if_co)
    );

    address_counter #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .OFFSET(RES_BASE),
        .WRAP_LEN(RES_WORDS)
    ) res_cnt (
        .clk(clk),
        .reset(reset),
        .clear(run_clear),
        .enable(res_ren),
        .addr(waddr),
        .co()
    );

    // one PE per filter+ifmap pass
    one_hot_counter #(
        .WIDTH(NUM_PE)
    ) pe_sel_cnt (
        .clk(clk),
        .reset(reset),
        .clear(run_clear),
        .count(if_co),
        .one_hot(pe_sel)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_IDLE;
            pe_wen     <= '0;
            pe_is_filt <= 1'b0;
        end else begin
            pe_wen     <= rd_en ? pe_sel : '0;  // sram data lands a cycle later
            pe_is_filt <= (state == S_LOAD_FILT);
            case (state)
                S_IDLE, S_DONE: begin
                    if (start) state <= S_LOAD_FILT;
                end
                S_LOAD_FILT: begin
                    if (filt_co) state <= S_LOAD_IF;
                end
                S_LOAD_IF: begin
                    if (if_co) state <= pe_sel[NUM_PE-1] ? S_SETTLE : S_LOAD_FILT;
                end
                S_SETTLE:  state <= S_LAUNCH;   // last PE write in flight
                S_LAUNCH:  state <= S_COMPUTE;
                S_COMPUTE: begin
                    if (res_ren && res_last) state <= S_DONE;
                end
                default:   state <= S_IDLE;
            endcase
        end
    end

    assign pe_start = (state == S_LAUNCH);

    // pop and write back in the same cycle
    assign res_ren    = (state == S_COMPUTE) && !res_empty;
    assign wen        = res_ren;
    assign wdata.psum = res_data;

    assign busy     = (state != S_IDLE) && (state != S_DONE);
    assign done_all = (state == S_DONE);

endmodule

//--- verilog/pe.sv
`timescale 1ns/1ns

module pe import conv_pkg::*; #(
    parameter bit FIRST           = 1'b0,
    parameter int PSUM_FIFO_DEPTH = 4
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       wen,
    input  logic       is_filt,
    input  sram_word_u din,
    input  logic       start,
    input  logic [1:0] taps,
    input  logic       stride2,
    psum_if.dst        up,
    psum_if.src        down
);

    localparam int FILT_PTR_W = $clog2(FILT_WORDS);
    localparam int IF_PTR_W   = $clog2(IF_WORDS);

    operand_t filt_spad [MAX_TAPS];
    operand_t if_spad [ROW_LEN];

    logic [FILT_PTR_W-1:0] filt_wptr;
    logic [IF_PTR_W-1:0]   if_wptr;

    logic       running;
    logic [1:0] taps_r;
    logic       stride2_r;
    logic [1:0] t;      // current tap
    logic [3:0] pix;    // first pixel of the window
    psum_t      acc;

    psum_t      up_head;
    logic       up_last;
    logic       up_empty;
    logic       up_ren;
    operand_t   pixel;
    operand_t   weight;
    psum_t      tap_sum;
    psum_t      up_val;
    logic [3:0] step;
    logic [4:0] next_end;
    logic       last_tap;
    logic       own_last;
    logic       row_last;
    logic       up_ready;
    logic       fire;

    // psums from the previous PE
    psum_fifo #(
        .PSUM_FIFO_DEPTH(PSUM_FIFO_DEPTH)
    ) in_fifo (
        .clk(clk),
        .reset(reset),
        .wen(up.wen),
        .din(up.data),
        .din_last(up.last),
        .ren(up_ren),
        .dout(up_head),
        .dout_last(up_last),
        .full(up.full),
        .empty(up_empty)
    );

    always_ff @(posedge clk) begin
        if (wen && is_filt) begin
            filt_spad[{filt_wptr, 1'b0}] <= din.ops[0];
            if ({filt_wptr, 1'b1} < MAX_TAPS) begin
                filt_spad[{filt_wptr, 1'b1}] <= din.ops[1];  // skip pad byte
            end
        end
        if (wen && !is_filt) begin
            if_spad[{if_wptr, 1'b0}] <= din.ops[0];
            if_spad[{if_wptr, 1'b1}] <= din.ops[1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || start) begin
            filt_wptr <= '0;
            if_wptr   <= '0;
        end else if (wen) begin
            if (is_filt) filt_wptr <= filt_wptr + 1'b1;
            else if_wptr <= if_wptr + 1'b1;
        end
    end

    assign step     = stride2_r ? 4'd2 : 4'd1;
    assign pixel    = if_spad[3'(pix + 4'(t))];
    assign weight   = filt_spad[t];
    assign tap_sum  = acc + pixel * weight;     // 16-bit wrap
    assign last_tap = (t == taps_r - 2'd1);

    // next window would run past the row
    assign next_end = 5'(pix) + 5'(step) + 5'(taps_r);
    assign own_last = (next_end > 5'(ROW_LEN));
    assign row_last = FIRST ? own_last : up_last;

    assign up_ready = FIRST || !up_empty;
    assign up_val   = FIRST ? '0 : up_head;
    assign fire     = running && last_tap && up_ready && !down.full;
    assign up_ren   = fire && !FIRST;

    assign down.wen  = fire;
    assign down.data = tap_sum + up_val;
    assign down.last = row_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            running   <= 1'b0;
            t         <= '0;
            pix       <= '0;
            taps_r    <= '0;
            stride2_r <= 1'b0;
        end else if (!running) begin
            if (start) begin
                running   <= 1'b1;
                t         <= '0;
                pix       <= '0;
                taps_r    <= taps;
                stride2_r <= stride2;
            end
        end else if (!last_tap) begin
            t <= t + 1'b1;
        end else if (fire) begin    // stalls here on back-pressure
            t       <= '0;
            pix     <= pix + step;
            running <= !row_last;
        end
    end

    always_ff @(posedge clk) begin
        if (start || fire) begin
            acc <= '0;
        end else if (running && !last_tap) begin
            acc <= tap_sum;
        end
    end

endmodule

//--- verilog/psum_fifo.sv
`timescale 1ns/1ns

module psum_fifo import conv_pkg::*; #(
    parameter int PSUM_FIFO_DEPTH = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  wen,
    input  psum_t din,
    input  logic  din_last,
    input  logic  ren,
    output psum_t dout,
    output logic  dout_last,
    output logic  full,
    output logic  empty
);

    localparam int PTR_W = (PSUM_FIFO_DEPTH > 1) ? $clog2(PSUM_FIFO_DEPTH) : 1;

    psum_t                      mem [PSUM_FIFO_DEPTH];
    logic [PSUM_FIFO_DEPTH-1:0] last_mem;
    logic [PTR_W-1:0]           wptr;
    logic [PTR_W-1:0]           rptr;
    logic [PTR_W:0]             count;
    logic                       push;
    logic                       pop;

    assign full  = (count == (PTR_W+1)'(PSUM_FIFO_DEPTH));
    assign empty = (count == '0);
    assign push  = wen && !full;
    assign pop   = ren && !empty;

    // head is visible without a read cycle
    assign dout      = mem[rptr];
    assign dout_last = last_mem[rptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wptr]      <= din;
            last_mem[wptr] <= din_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) wptr <= (wptr == PTR_W'(PSUM_FIFO_DEPTH - 1)) ? '0 : wptr + 1'b1;
            if (pop) rptr <= (rptr == PTR_W'(PSUM_FIFO_DEPTH - 1)) ? '0 : rptr + 1'b1;
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

endmodule

//--- verilog/one_hot_counter.sv
`timescale 1ns/1ns

module one_hot_counter #(
    parameter int WIDTH = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             clear,
    input  logic             count,
    output logic [WIDTH-1:0] one_hot
);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            one_hot <= WIDTH'(1);
        end else if (count) begin
            one_hot <= {one_hot[WIDTH-2:0], one_hot[WIDTH-1]};  // rotate left
        end
    end

endmodule

//--- verilog/address_counter.sv
`timescale 1ns/1ns

module address_counter #(
    parameter int ADDR_WIDTH = 6,
    parameter int OFFSET     = 0,
    parameter int WRAP_LEN   = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  enable,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic                  co
);

    localparam int STEP_W = (WRAP_LEN > 1) ? $clog2(WRAP_LEN) : 1;

    logic [STEP_W-1:0] step;
    logic              last_step;

    assign last_step = (step == STEP_W'(WRAP_LEN - 1));
    assign co = enable && last_step;

    // step count wraps while the address runs on until the next clear
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            addr <= ADDR_WIDTH'(OFFSET);
            step <= '0;
        end else if (enable) begin
            addr <= addr + 1'b1;
            step <= last_step ? '0 : step + 1'b1;
        end
    end

endmodule

//--- verilog/sram.sv
`timescale 1ns/1ns

module sram import conv_pkg::*; #(
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic                  wen,
    input  sram_word_u            wdata,
    output sram_word_u            rdata
);

    sram_word_u mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];    // old data on a same-address write
    end

endmodule

//--- verilog/psum_if.sv
`timescale 1ns/1ns

interface psum_if import conv_pkg::*; ();

    logic  wen;
    psum_t data;
    logic  last;    // final psum of the row
    logic  full;

    // upstream pushes only while full is low
    modport src (output wen, output data, output last, input full);
    modport dst (input wen, input data, input last, output full);

endinterface

//--- verilog/map_pkg.sv
package map_pkg;

    localparam int ADDR_W = 6;

    // two words per filter row
    localparam int FILT_BASE = 0;

    // four words per ifmap row
    localparam int IF_BASE = 8;

    localparam int RES_BASE  = 32;
    localparam int RES_WORDS = 8;   // longest output row at taps 1 stride 1

endpackage

//--- verilog/conv_pkg.sv
package conv_pkg;

    // unsigned pixel or weight
    typedef logic [7:0] operand_t;

    // partial or final sum that wraps at 2^16
    typedef logic [15:0] psum_t;

    // one sram word seen as operands on load and as a psum on write-back
    typedef union packed {
        operand_t [1:0] ops;    // ops[0] is the low byte
        psum_t          psum;
    } sram_word_u;

    localparam int ROW_LEN  = 8;    // pixels per ifmap row
    localparam int MAX_TAPS = 3;
    localparam int NUM_PE   = 3;

    localparam int IF_WORDS   = ROW_LEN / 2;
    localparam int FILT_WORDS = 2;  // tap 3 word carries a pad byte

endpackage
